// ==== hw/tof_hist_macros.svh ====
`ifndef TOF_HIST_MACROS_SVH
`define TOF_HIST_MACROS_SVH

// bin index width, 16 bins per bank
`define TOF_BIN_W 4
`define TOF_BIN_NUM 16

// bin counter width, saturates at 15
`define TOF_CNT_W 4

// nested loop lengths
// inputs per pixel
`define TOF_DATA_NUM 4
// pixels per acquisition
`define TOF_PIXEL_NUM 2
// acquisitions per histogram
`define TOF_ACQ_NUM 3

// events in one complete histogram
`define TOF_HIST_EVENTS (`TOF_DATA_NUM * `TOF_PIXEL_NUM * `TOF_ACQ_NUM)

`endif

// ==== hw/tof_hist_pkg.sv ====
`default_nettype none

package tof_hist_pkg;

    // builder FSM
    typedef enum logic [2:0] {
        RESET_ALL,
        INPUT_COUNT,
        MEM_WAIT,
        ACK_HOLD,
        SWAP_WAIT
    } hist_state_t;

    // readout FSM
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_MEM,
        RD_OUT,
        RD_RELEASE
    } rd_state_t;

    // bin memory opcodes
    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_INC,
        MEM_READ_CLEAR
    } mem_op_t;

endpackage

`default_nettype wire

// ==== hw/bin_memory.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tof_hist_macros.svh"

module bin_memory (
    input  wire                       clk,
    input  wire                       res,
    input  wire tof_hist_pkg::mem_op_t op,
    input  wire                       bank,
    input  wire [`TOF_BIN_W-1:0]      bin,
    output logic [`TOF_CNT_W-1:0]     rdata
);
    import tof_hist_pkg::*;

    // two banks of bin counters
    logic [`TOF_CNT_W-1:0] mem [0:1][0:`TOF_BIN_NUM-1];

    // one opcode per cycle
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            // whole array cleared on reset
            for (int b = 0; b < 2; b++) begin
                for (int i = 0; i < `TOF_BIN_NUM; i++) begin
                    mem[b][i] <= '0;
                end
            end
        end else begin
            case (op)
                MEM_INC: begin
                    // hold at full scale
                    if (mem[bank][bin] != '1) begin
                        mem[bank][bin] <= mem[bank][bin] + 1'b1;
                    end
                end
                MEM_READ_CLEAR: mem[bank][bin] <= '0;
                default: ;
            endcase
        end
    end

    // old value captured on read-clear only, so it stays put across increments
    always_ff @(posedge clk) begin
        if (op == MEM_READ_CLEAR) begin
            rdata <= mem[bank][bin];
        end
    end

endmodule

`default_nettype wire

// ==== hw/bin_arbiter.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tof_hist_macros.svh"

module bin_arbiter (
    input  wire                        clk,
    input  wire                        res,
    // builder client, implicit increment
    input  wire                        bld_req,
    input  wire                        bld_bank,
    input  wire [`TOF_BIN_W-1:0]       bld_bin,
    output logic                       bld_ack,
    // readout client, implicit read-clear
    input  wire                        rd_req,
    input  wire                        rd_bank,
    input  wire [`TOF_BIN_W-1:0]       rd_bin,
    output logic                       rd_ack,
    output logic [`TOF_CNT_W-1:0]      rd_count,
    // bin memory side
    output tof_hist_pkg::mem_op_t      mem_op,
    output logic                       mem_bank,
    output logic [`TOF_BIN_W-1:0]      mem_bin,
    input  wire [`TOF_CNT_W-1:0]       mem_rdata
);
    import tof_hist_pkg::*;

    // current owner of the memory
    logic gnt_bld;
    logic gnt_rd;
    logic gnt_free;

    assign gnt_free = !gnt_bld && !gnt_rd;

    // owner, opcode pulse and acks
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            gnt_bld <= 1'b0;
            gnt_rd  <= 1'b0;
            mem_op  <= MEM_IDLE;
            bld_ack <= 1'b0;
            rd_ack  <= 1'b0;
        end else begin
            // opcode lasts a single cycle
            mem_op <= MEM_IDLE;
            if (gnt_free) begin
                // builder wins a tie
                if (bld_req) begin
                    gnt_bld <= 1'b1;
                    mem_op  <= MEM_INC;
                end else if (rd_req) begin
                    gnt_rd <= 1'b1;
                    mem_op <= MEM_READ_CLEAR;
                end
            end else if (gnt_bld) begin
                // ack the cycle after the op, drop it after req falls
                if (mem_op == MEM_INC) begin
                    bld_ack <= 1'b1;
                end else if (bld_ack && !bld_req) begin
                    bld_ack <= 1'b0;
                    gnt_bld <= 1'b0;
                end
            end else begin
                if (mem_op == MEM_READ_CLEAR) begin
                    rd_ack <= 1'b1;
                end else if (rd_ack && !rd_req) begin
                    rd_ack <= 1'b0;
                    gnt_rd <= 1'b0;
                end
            end
        end
    end

    // address latched together with the grant
    always_ff @(posedge clk) begin
        if (gnt_free) begin
            if (bld_req) begin
                mem_bank <= bld_bank;
                mem_bin  <= bld_bin;
            end else if (rd_req) begin
                mem_bank <= rd_bank;
                mem_bin  <= rd_bin;
            end
        end
    end

    // rdata only moves on a read-clear, none can happen while rd holds the grant
    assign rd_count = mem_rdata;

endmodule

`default_nettype wire

// ==== hw/his_builder.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tof_hist_macros.svh"

module his_builder (
    input  wire                   clk,
    input  wire                   res,
    // event input
    input  wire                   ev_req,
    input  wire [`TOF_BIN_W-1:0]  ev_bin,
    output logic                  ev_ack,
    // arbiter client
    output logic                  bld_req,
    output logic                  bld_bank,
    output logic [`TOF_BIN_W-1:0] bld_bin,
    input  wire                   bld_ack,
    // bank control
    input  wire                   drain_busy,
    output logic                  hist_num,
    output logic                  drain_start
);
    import tof_hist_pkg::*;

    hist_state_t state;

    // nested loop counters
    logic [$clog2(`TOF_DATA_NUM)-1:0]  input_count;
    logic [$clog2(`TOF_PIXEL_NUM)-1:0] pixel_count;
    logic [$clog2(`TOF_ACQ_NUM)-1:0]   acq_count;

    logic input_last;
    logic pixel_last;
    logic acq_last;
    logic hist_last;
    logic ev_take;

    assign input_last = (input_count == `TOF_DATA_NUM - 1);
    assign pixel_last = (pixel_count == `TOF_PIXEL_NUM - 1);
    assign acq_last   = (acq_count == `TOF_ACQ_NUM - 1);
    // 24th event of the histogram
    assign hist_last  = input_last && pixel_last && acq_last;

    // new event, previous memory handshake fully closed
    assign ev_take = (state == INPUT_COUNT) && ev_req && !bld_ack;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= RESET_ALL;
            input_count <= '0;
            pixel_count <= '0;
            acq_count   <= '0;
            ev_ack      <= 1'b0;
            bld_req     <= 1'b0;
            hist_num    <= 1'b0;
            drain_start <= 1'b0;
        end else begin
            drain_start <= 1'b0;
            case (state)
                RESET_ALL: begin
                    input_count <= '0;
                    pixel_count <= '0;
                    acq_count   <= '0;
                    state       <= INPUT_COUNT;
                end
                INPUT_COUNT: begin
                    if (ev_take) begin
                        bld_req <= 1'b1;
                        state   <= MEM_WAIT;
                    end
                end
                MEM_WAIT: begin
                    // increment is in memory, hand the ack out
                    if (bld_ack) begin
                        bld_req <= 1'b0;
                        ev_ack  <= 1'b1;
                        state   <= ACK_HOLD;
                    end
                end
                ACK_HOLD: begin
                    if (!ev_req) begin
                        ev_ack <= 1'b0;
                        // advance with carry, wraps to zero on the last event
                        if (input_last) begin
                            input_count <= '0;
                            if (pixel_last) begin
                                pixel_count <= '0;
                                if (acq_last) begin
                                    acq_count <= '0;
                                end else begin
                                    acq_count <= acq_count + 1'b1;
                                end
                            end else begin
                                pixel_count <= pixel_count + 1'b1;
                            end
                        end else begin
                            input_count <= input_count + 1'b1;
                        end
                        if (hist_last && drain_busy) begin
                            // other bank still draining
                            state <= SWAP_WAIT;
                        end else if (hist_last) begin
                            hist_num    <= ~hist_num;
                            drain_start <= 1'b1;
                            state       <= INPUT_COUNT;
                        end else begin
                            state <= INPUT_COUNT;
                        end
                    end
                end
                SWAP_WAIT: begin
                    // no events taken until the swap
                    if (!drain_busy) begin
                        hist_num    <= ~hist_num;
                        drain_start <= 1'b1;
                        state       <= INPUT_COUNT;
                    end
                end
                default: state <= RESET_ALL;
            endcase
        end
    end

    // memory address taken with the event
    always_ff @(posedge clk) begin
        if (ev_take) begin
            bld_bank <= hist_num;
            bld_bin  <= ev_bin;
        end
    end

endmodule

`default_nettype wire

// ==== hw/his_readout.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tof_hist_macros.svh"

module his_readout (
    input  wire                   clk,
    input  wire                   res,
    // bank control
    input  wire                   drain_start,
    input  wire                   hist_num,
    // arbiter client
    output logic                  rd_req,
    output logic                  rd_bank,
    output logic [`TOF_BIN_W-1:0] rd_bin,
    input  wire                   rd_ack,
    input  wire [`TOF_CNT_W-1:0]  rd_count,
    output logic                  drain_busy,
    // bin output
    output logic                  out_req,
    output logic [`TOF_BIN_W-1:0] out_bin,
    output logic [`TOF_CNT_W-1:0] out_count,
    output logic                  out_last,
    input  wire                   out_ack
);
    import tof_hist_pkg::*;

    rd_state_t state;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= RD_IDLE;
            rd_req     <= 1'b0;
            rd_bin     <= '0;
            drain_busy <= 1'b0;
            out_req    <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    // start at bin 0 of the finished bank
                    if (drain_start) begin
                        rd_bin     <= '0;
                        rd_req     <= 1'b1;
                        drain_busy <= 1'b1;
                        state      <= RD_MEM;
                    end
                end
                RD_MEM: begin
                    // read-clear done, present the bin
                    if (rd_ack) begin
                        rd_req  <= 1'b0;
                        out_req <= 1'b1;
                        state   <= RD_OUT;
                    end
                end
                RD_OUT: begin
                    // stalls here while the sink holds off
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= RD_RELEASE;
                    end
                end
                RD_RELEASE: begin
                    // both handshakes must be back to idle
                    if (!out_ack && !rd_ack) begin
                        if (rd_bin == `TOF_BIN_NUM - 1) begin
                            drain_busy <= 1'b0;
                            state      <= RD_IDLE;
                        end else begin
                            rd_bin <= rd_bin + 1'b1;
                            rd_req <= 1'b1;
                            state  <= RD_MEM;
                        end
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // drained bank is the one no longer being filled
    always_ff @(posedge clk) begin
        if (state == RD_IDLE && drain_start) begin
            rd_bank <= ~hist_num;
        end
    end

    // output data held while out_req is high
    always_ff @(posedge clk) begin
        if (state == RD_MEM && rd_ack) begin
            out_bin   <= rd_bin;
            out_count <= rd_count;
            out_last  <= (rd_bin == `TOF_BIN_NUM - 1);
        end
    end

endmodule

`default_nettype wire

// ==== hw/tof_hist_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tof_hist_macros.svh"

module tof_hist_top (
    input  wire                   clk,
    input  wire                   res,
    input  wire                   ev_req,
    input  wire [`TOF_BIN_W-1:0]  ev_bin,
    output wire                   ev_ack,
    output wire                   out_req,
    output wire [`TOF_BIN_W-1:0]  out_bin,
    output wire [`TOF_CNT_W-1:0]  out_count,
    output wire                   out_last,
    input  wire                   out_ack,
    output wire                   hist_num
);
    // builder to arbiter
    wire                  bld_req;
    wire                  bld_bank;
    wire [`TOF_BIN_W-1:0] bld_bin;
    wire                  bld_ack;
    // readout to arbiter
    wire                  rd_req;
    wire                  rd_bank;
    wire [`TOF_BIN_W-1:0] rd_bin;
    wire                  rd_ack;
    wire [`TOF_CNT_W-1:0] rd_count;
    // arbiter to memory
    wire tof_hist_pkg::mem_op_t mem_op;
    wire                  mem_bank;
    wire [`TOF_BIN_W-1:0] mem_bin;
    wire [`TOF_CNT_W-1:0] mem_rdata;
    // bank control
    wire                  drain_start;
    wire                  drain_busy;

    his_builder u_builder (
        .clk(clk), .res(res),
        .ev_req(ev_req), .ev_bin(ev_bin), .ev_ack(ev_ack),
        .bld_req(bld_req), .bld_bank(bld_bank), .bld_bin(bld_bin), .bld_ack(bld_ack),
        .drain_busy(drain_busy), .hist_num(hist_num), .drain_start(drain_start)
    );

    his_readout u_readout (
        .clk(clk), .res(res),
        .drain_start(drain_start), .hist_num(hist_num),
        .rd_req(rd_req), .rd_bank(rd_bank), .rd_bin(rd_bin),
        .rd_ack(rd_ack), .rd_count(rd_count), .drain_busy(drain_busy),
        .out_req(out_req), .out_bin(out_bin), .out_count(out_count),
        .out_last(out_last), .out_ack(out_ack)
    );

    bin_arbiter u_arbiter (
        .clk(clk), .res(res),
        .bld_req(bld_req), .bld_bank(bld_bank), .bld_bin(bld_bin), .bld_ack(bld_ack),
        .rd_req(rd_req), .rd_bank(rd_bank), .rd_bin(rd_bin),
        .rd_ack(rd_ack), .rd_count(rd_count),
        .mem_op(mem_op), .mem_bank(mem_bank), .mem_bin(mem_bin), .mem_rdata(mem_rdata)
    );

    bin_memory u_memory (
        .clk(clk), .res(res),
        .op(mem_op), .bank(mem_bank), .bin(mem_bin), .rdata(mem_rdata)
    );

endmodule

`default_nettype wire

// ==== bench/tof_hist_assert.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tof_hist_macros.svh"

module tof_hist_assert (
    input wire                  clk,
    input wire                  res,
    input wire                  ev_req,
    input wire                  ev_ack,
    input wire                  out_req,
    input wire [`TOF_BIN_W-1:0] out_bin,
    input wire [`TOF_CNT_W-1:0] out_count,
    input wire                  out_last,
    input wire                  out_ack,
    input wire                  bld_ack,
    input wire                  rd_ack,
    input wire                  drain_start
);
    // count of failed assertions
    int fail_count = 0;

    // event ack only answers a pending request
    ev_ack_needs_req: assert property (@(posedge clk) disable iff (!res)
        $rose(ev_ack) |-> $past(ev_req))
        else begin
            fail_count++;
            $error("ev_ack rose without ev_req");
        end

    // output word frozen until the sink takes it
    out_held: assert property (@(posedge clk) disable iff (!res)
        (out_req && !out_ack) |=> (out_req && $stable(out_bin)
            && $stable(out_count) && $stable(out_last)))
        else begin
            fail_count++;
            $error("out_req or its data moved before out_ack");
        end

    // one memory client at a time
    one_grant: assert property (@(posedge clk) disable iff (!res)
        !(bld_ack && rd_ack))
        else begin
            fail_count++;
            $error("bld_ack and rd_ack high together");
        end

    // swap marker is a single cycle
    drain_pulse: assert property (@(posedge clk) disable iff (!res)
        drain_start |=> !drain_start)
        else begin
            fail_count++;
            $error("drain_start longer than one cycle");
        end

endmodule

// hooked onto the top level, internal arbiter and bank nets included
bind tof_hist_top tof_hist_assert u_assert (
    .clk(clk), .res(res),
    .ev_req(ev_req), .ev_ack(ev_ack),
    .out_req(out_req), .out_bin(out_bin), .out_count(out_count),
    .out_last(out_last), .out_ack(out_ack),
    .bld_ack(bld_ack), .rd_ack(rd_ack), .drain_start(drain_start)
);

`default_nettype wire

// ==== bench/tof_hist_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "tof_hist_macros.svh"

module tof_hist_tb;

    localparam int WAIT_LIMIT = 4000;
    localparam int CNT_MAX    = (1 << `TOF_CNT_W) - 1;

    logic                  clk;
    logic                  res;
    logic                  ev_req;
    logic [`TOF_BIN_W-1:0] ev_bin;
    wire                   ev_ack;
    wire                   out_req;
    wire [`TOF_BIN_W-1:0]  out_bin;
    wire [`TOF_CNT_W-1:0]  out_count;
    wire                   out_last;
    logic                  out_ack;
    wire                   hist_num;

    // events of the histogram being filled, then finished ones awaiting drain
    int cur_events[$];
    int done_events[$];
    int ev_total;
    int exp_bin;
    int ack_delay_max;
    logic [31:0] stim_seed;
    logic [31:0] ack_seed;

    int check_count;
    int err_count;
    int tests_passed;
    int tests_failed;
    int errs_before;

    // raised by a wait that ran past its limit
    event timeout_ev;
    string timeout_what;

    tof_hist_top dut0 (
        .clk(clk), .res(res),
        .ev_req(ev_req), .ev_bin(ev_bin), .ev_ack(ev_ack),
        .out_req(out_req), .out_bin(out_bin), .out_count(out_count),
        .out_last(out_last), .out_ack(out_ack),
        .hist_num(hist_num)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // saturating occurrence count of a bin in the oldest finished histogram
    function automatic int expected_count(input int bin);
        int n;
        n = 0;
        for (int i = 0; i < `TOF_HIST_EVENTS; i++) begin
            if (done_events[i] == bin) begin
                n++;
            end
        end
        if (n > CNT_MAX) begin
            n = CNT_MAX;
        end
        return n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // ends the run once any wait has gone on too long
    initial begin : watchdog
        @(timeout_ev);
        $display("timeout after %0d cycles at %0t: %s", WAIT_LIMIT, $time, timeout_what);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // one cycle step, flags a wait that has gone on too long
    task automatic step_or_abort(input int n, input string what);
        if (n >= WAIT_LIMIT) begin
            timeout_what = what;
            -> timeout_ev;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        res = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        res = 1'b1;
    endtask

    // full four-phase event, called 1 ns after an edge
    task automatic send_event(input logic [`TOF_BIN_W-1:0] bin);
        int n;
        ev_bin = bin;
        ev_req = 1'b1;
        n = 0;
        while (!ev_ack) begin
            step_or_abort(n, "ev_ack never rose for a pending event");
            n++;
        end
        // bank flips every 24 acknowledged events
        check_value("hist_num", hist_num, (ev_total / `TOF_HIST_EVENTS) % 2);
        cur_events.push_back(bin);
        ev_total++;
        if (cur_events.size() == `TOF_HIST_EVENTS) begin
            foreach (cur_events[i]) begin
                done_events.push_back(cur_events[i]);
            end
            cur_events.delete();
        end
        ev_req = 1'b0;
        n = 0;
        while (ev_ack) begin
            step_or_abort(n, "ev_ack stayed high after ev_req fell");
            n++;
        end
    endtask

    task automatic send_random(input int count);
        for (int i = 0; i < count; i++) begin
            stim_seed = lcg_step(stim_seed);
            send_event(stim_seed[23:20]);
        end
    endtask

    // all finished histograms drained and the bank swapped
    task automatic wait_drained();
        int n;
        n = 0;
        while (done_events.size() != 0 || out_req) begin
            step_or_abort(n, "histogram drain did not finish");
            n++;
        end
        check_value("hist_num", hist_num, (ev_total / `TOF_HIST_EVENTS) % 2);
    endtask

    task automatic report_test(input string name);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, err_count - errs_before);
        end
        errs_before = err_count;
    endtask

    // sink side, takes each bin with a random hold-off and compares it
    initial begin : output_compare
        int delay;
        int n;
        int tmp;
        forever begin
            @(posedge clk);
            #1;
            if (res && out_req && !out_ack) begin
                ack_seed = lcg_step(ack_seed);
                delay = ack_seed[23:16] % (ack_delay_max + 1);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                if (done_events.size() < `TOF_HIST_EVENTS) begin
                    err_count++;
                    $display("out_req raised at %0t with no finished histogram pending",
                             $time);
                end else begin
                    check_value("out_bin", out_bin, exp_bin);
                    check_value("out_count", out_count, expected_count(exp_bin));
                    check_value("out_last", out_last, exp_bin == `TOF_BIN_NUM - 1);
                end
                out_ack = 1'b1;
                n = 0;
                while (out_req) begin
                    step_or_abort(n, "out_req stayed high after out_ack");
                    n++;
                end
                out_ack = 1'b0;
                if (exp_bin == `TOF_BIN_NUM - 1) begin
                    // histogram done, drop its events
                    exp_bin = 0;
                    repeat (`TOF_HIST_EVENTS) begin
                        if (done_events.size() != 0) begin
                            tmp = done_events.pop_front();
                        end
                    end
                end else begin
                    exp_bin++;
                end
            end
        end
    end

    initial begin : stimulus
        res = 1'b0;
        ev_req = 1'b0;
        ev_bin = '0;
        out_ack = 1'b0;
        ev_total = 0;
        exp_bin = 0;
        ack_delay_max = 3;
        stim_seed = 32'd87897;
        ack_seed = 32'd87897;
        check_count = 0;
        err_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        errs_before = 0;
        timeout_what = "";
        apply_reset();

        // spread over all bins, some twice
        for (int i = 0; i < `TOF_HIST_EVENTS; i++) begin
            send_event((i * 7) % `TOF_BIN_NUM);
        end
        wait_drained();
        report_test("single histogram");

        // back to back, each drain on its own
        send_random(4 * `TOF_HIST_EVENTS);
        wait_drained();
        report_test("random histograms");

        // one bin past full scale
        for (int i = 0; i < `TOF_HIST_EVENTS; i++) begin
            send_event(4'd9);
        end
        wait_drained();
        report_test("saturation");

        // slow sink, builder has to wait for the other bank
        ack_delay_max = 40;
        send_random(3 * `TOF_HIST_EVENTS);
        wait_drained();
        ack_delay_max = 3;
        report_test("slow sink");

        // partial histogram in bank 1 thrown away by reset
        send_random(10);
        apply_reset();
        cur_events.delete();
        done_events.delete();
        ev_total = 0;
        exp_bin = 0;
        check_value("hist_num", hist_num, 0);
        // second histogram lands in the bank that held the partial one
        send_random(2 * `TOF_HIST_EVENTS);
        wait_drained();
        report_test("mid-histogram reset");

        $display("tests passed %0d failed %0d, checks %0d errors %0d, assertion failures %0d",
                 tests_passed, tests_failed, check_count, err_count,
                 dut0.u_assert.fail_count);
        if (err_count == 0 && tests_failed == 0 && dut0.u_assert.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tof_hist.f ====
+incdir+hw
hw/tof_hist_pkg.sv
hw/bin_memory.sv
hw/bin_arbiter.sv
hw/his_builder.sv
hw/his_readout.sv
hw/tof_hist_top.sv
bench/tof_hist_assert.sv
bench/tof_hist_tb.sv
